// File: hdl/wb_pkg.sv
// Back end package with word widths, register counts and machine CSR addresses
package wb_pkg;

  // data path
  localparam int XLEN        = 32;
  localparam int INST_WD     = 32;

  // general registers
  localparam int GPR_ADDR_WD = 5;
  localparam int GPR_NUM     = 32;

  // machine CSR address space
  localparam int CSR_ADDR_WD = 12;

  localparam logic [CSR_ADDR_WD-1:0] CSR_MSTATUS = 12'h300;
  localparam logic [CSR_ADDR_WD-1:0] CSR_MTVEC   = 12'h305;
  localparam logic [CSR_ADDR_WD-1:0] CSR_MEPC    = 12'h341;
  localparam logic [CSR_ADDR_WD-1:0] CSR_MCAUSE  = 12'h342;

endpackage

// File: hdl/wb_stage.sv
// Write-back stage that registers the retiring instruction and steers its writes
`timescale 1ns/100ps

module wb_stage
  import wb_pkg::*;
(
  input  logic                   i_clk,
  input  logic                   i_arst_n,
  // from memory stage
  input  logic                   i_ms_valid,
  input  logic                   i_ms_gpr_wen,
  input  logic [GPR_ADDR_WD-1:0] i_ms_rd,
  input  logic [XLEN-1:0]        i_ms_gpr_result,
  input  logic                   i_ms_csr_wen,
  input  logic [CSR_ADDR_WD-1:0] i_ms_csr_addr,
  input  logic [XLEN-1:0]        i_ms_csr_result,
  input  logic [XLEN-1:0]        i_ms_pc,
  input  logic [INST_WD-1:0]     i_ms_inst,
  // to gpr file and bypass
  output logic                   o_gpr_we,
  output logic [GPR_ADDR_WD-1:0] o_gpr_waddr,
  output logic [XLEN-1:0]        o_gpr_wdata,
  // to csr file and bypass
  output logic                   o_csr_we,
  output logic [CSR_ADDR_WD-1:0] o_csr_waddr,
  output logic [XLEN-1:0]        o_csr_wdata,
  // commit trace
  output logic                   o_commit_valid,
  output logic [XLEN-1:0]        o_commit_pc,
  output logic [INST_WD-1:0]     o_commit_inst
);

  logic                   ws_valid;
  logic                   ws_gpr_wen;
  logic [GPR_ADDR_WD-1:0] ws_rd;
  logic [XLEN-1:0]        ws_gpr_result;
  logic                   ws_csr_wen;
  logic [CSR_ADDR_WD-1:0] ws_csr_addr;
  logic [XLEN-1:0]        ws_csr_result;
  logic [XLEN-1:0]        ws_pc;
  logic [INST_WD-1:0]     ws_inst;

  // ready-go is always true, so the stage takes a new instruction every cycle
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      ws_valid <= 1'b0;
    end else begin
      ws_valid <= i_ms_valid;
    end
  end

  // payload holds while no instruction arrives
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      ws_gpr_wen    <= 1'b0;
      ws_rd         <= '0;
      ws_gpr_result <= '0;
      ws_csr_wen    <= 1'b0;
      ws_csr_addr   <= '0;
      ws_csr_result <= '0;
      ws_pc         <= '0;
      ws_inst       <= '0;
    end else if (i_ms_valid) begin
      ws_gpr_wen    <= i_ms_gpr_wen;
      ws_rd         <= i_ms_rd;
      ws_gpr_result <= i_ms_gpr_result;
      ws_csr_wen    <= i_ms_csr_wen;
      ws_csr_addr   <= i_ms_csr_addr;
      ws_csr_result <= i_ms_csr_result;
      ws_pc         <= i_ms_pc;
      ws_inst       <= i_ms_inst;
    end
  end

  // x0 writes dropped here so the bypass never sees them
  assign o_gpr_we    = ws_valid && ws_gpr_wen && (ws_rd != '0);
  assign o_gpr_waddr = ws_rd;
  assign o_gpr_wdata = ws_gpr_result;

  assign o_csr_we    = ws_valid && ws_csr_wen;
  assign o_csr_waddr = ws_csr_addr;
  assign o_csr_wdata = ws_csr_result;

  assign o_commit_valid = ws_valid;
  assign o_commit_pc    = ws_pc;
  assign o_commit_inst  = ws_inst;

endmodule

// File: hdl/gpr_file.sv
// General register file with 31 writable registers, hard-wired x0 and two read ports
`timescale 1ns/100ps

module gpr_file
  import wb_pkg::*;
(
  input  logic                   i_clk,
  input  logic                   i_arst_n,
  // write port
  input  logic                   i_we,
  input  logic [GPR_ADDR_WD-1:0] i_waddr,
  input  logic [XLEN-1:0]        i_wdata,
  // read ports
  input  logic [GPR_ADDR_WD-1:0] i_raddr1,
  input  logic [GPR_ADDR_WD-1:0] i_raddr2,
  output logic [XLEN-1:0]        o_rdata1,
  output logic [XLEN-1:0]        o_rdata2
);

  // no storage behind x0
  logic [XLEN-1:0] regs [GPR_NUM-1:1];

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int i = 1; i < GPR_NUM; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && (i_waddr != '0)) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  // asynchronous reads with x0 reading zero
  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

// File: hdl/csr_file.sv
// Machine CSR file holding mstatus, mtvec, mepc and mcause with one write and one read port
`timescale 1ns/100ps

module csr_file
  import wb_pkg::*;
(
  input  logic                   i_clk,
  input  logic                   i_arst_n,
  // write port
  input  logic                   i_we,
  input  logic [CSR_ADDR_WD-1:0] i_waddr,
  input  logic [XLEN-1:0]        i_wdata,
  // read port
  input  logic [CSR_ADDR_WD-1:0] i_raddr,
  output logic [XLEN-1:0]        o_rdata
);

  logic [XLEN-1:0] mstatus;
  logic [XLEN-1:0] mtvec;
  logic [XLEN-1:0] mepc;
  logic [XLEN-1:0] mcause;

  // writes to other addresses fall through the decode
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      mstatus <= '0;
      mtvec   <= '0;
      mepc    <= '0;
      mcause  <= '0;
    end else if (i_we) begin
      case (i_waddr)
        CSR_MSTATUS: mstatus <= i_wdata;
        CSR_MTVEC:   mtvec   <= i_wdata;
        CSR_MEPC:    mepc    <= i_wdata;
        CSR_MCAUSE:  mcause  <= i_wdata;
        default: begin
        end
      endcase
    end
  end

  // unsupported addresses read zero
  always_comb begin
    case (i_raddr)
      CSR_MSTATUS: o_rdata = mstatus;
      CSR_MTVEC:   o_rdata = mtvec;
      CSR_MEPC:    o_rdata = mepc;
      CSR_MCAUSE:  o_rdata = mcause;
      default:     o_rdata = '0;
    endcase
  end

endmodule

// File: hdl/operand_forward.sv
// Operand forwarding that bypasses the pending write-back data to the decode reads
`timescale 1ns/100ps

module operand_forward
  import wb_pkg::*;
(
  // decode read addresses
  input  logic [GPR_ADDR_WD-1:0] i_ds_rs1,
  input  logic [GPR_ADDR_WD-1:0] i_ds_rs2,
  input  logic [CSR_ADDR_WD-1:0] i_ds_csr_addr,
  // pending write from write-back
  input  logic                   i_gpr_we,
  input  logic [GPR_ADDR_WD-1:0] i_gpr_waddr,
  input  logic [XLEN-1:0]        i_gpr_wdata,
  input  logic                   i_csr_we,
  input  logic [CSR_ADDR_WD-1:0] i_csr_waddr,
  input  logic [XLEN-1:0]        i_csr_wdata,
  // register file reads
  input  logic [XLEN-1:0]        i_gpr_rdata1,
  input  logic [XLEN-1:0]        i_gpr_rdata2,
  input  logic [XLEN-1:0]        i_csr_rdata,
  // to decode
  output logic [XLEN-1:0]        o_rs1_val,
  output logic [XLEN-1:0]        o_rs2_val,
  output logic [XLEN-1:0]        o_csr_val
);

  logic rs1_hit;
  logic rs2_hit;
  logic csr_supported;
  logic csr_hit;

  // gpr_we is already low for rd zero
  assign rs1_hit = i_gpr_we && (i_gpr_waddr == i_ds_rs1);
  assign rs2_hit = i_gpr_we && (i_gpr_waddr == i_ds_rs2);

  // the csr file keeps its decode to itself, so repeat it for the bypass
  assign csr_supported = (i_csr_waddr == CSR_MSTATUS) ||
                         (i_csr_waddr == CSR_MTVEC)   ||
                         (i_csr_waddr == CSR_MEPC)    ||
                         (i_csr_waddr == CSR_MCAUSE);
  assign csr_hit = i_csr_we && csr_supported && (i_csr_waddr == i_ds_csr_addr);

  assign o_rs1_val = rs1_hit ? i_gpr_wdata : i_gpr_rdata1;
  assign o_rs2_val = rs2_hit ? i_gpr_wdata : i_gpr_rdata2;
  assign o_csr_val = csr_hit ? i_csr_wdata : i_csr_rdata;

endmodule

// File: hdl/wb_backend_top.sv
// Pipeline back end top that joins the write-back stage, register files and forwarding
`timescale 1ns/100ps

module wb_backend_top
  import wb_pkg::*;
(
  input  logic                   i_clk,
  input  logic                   i_arst_n,
  // from memory stage
  input  logic                   i_ms_valid,
  input  logic                   i_ms_gpr_wen,
  input  logic [GPR_ADDR_WD-1:0] i_ms_rd,
  input  logic [XLEN-1:0]        i_ms_gpr_result,
  input  logic                   i_ms_csr_wen,
  input  logic [CSR_ADDR_WD-1:0] i_ms_csr_addr,
  input  logic [XLEN-1:0]        i_ms_csr_result,
  input  logic [XLEN-1:0]        i_ms_pc,
  input  logic [INST_WD-1:0]     i_ms_inst,
  // decode reads
  input  logic [GPR_ADDR_WD-1:0] i_ds_rs1,
  input  logic [GPR_ADDR_WD-1:0] i_ds_rs2,
  input  logic [CSR_ADDR_WD-1:0] i_ds_csr_addr,
  output logic [XLEN-1:0]        o_ds_rs1_val,
  output logic [XLEN-1:0]        o_ds_rs2_val,
  output logic [XLEN-1:0]        o_ds_csr_val,
  // commit trace
  output logic                   o_commit_valid,
  output logic [XLEN-1:0]        o_commit_pc,
  output logic [INST_WD-1:0]     o_commit_inst
);

  logic                   gpr_we;
  logic [GPR_ADDR_WD-1:0] gpr_waddr;
  logic [XLEN-1:0]        gpr_wdata;
  logic                   csr_we;
  logic [CSR_ADDR_WD-1:0] csr_waddr;
  logic [XLEN-1:0]        csr_wdata;
  logic [XLEN-1:0]        gpr_rdata1;
  logic [XLEN-1:0]        gpr_rdata2;
  logic [XLEN-1:0]        csr_rdata;

  wb_stage u_wb_stage (
    .i_clk           (i_clk),
    .i_arst_n        (i_arst_n),
    .i_ms_valid      (i_ms_valid),
    .i_ms_gpr_wen    (i_ms_gpr_wen),
    .i_ms_rd         (i_ms_rd),
    .i_ms_gpr_result (i_ms_gpr_result),
    .i_ms_csr_wen    (i_ms_csr_wen),
    .i_ms_csr_addr   (i_ms_csr_addr),
    .i_ms_csr_result (i_ms_csr_result),
    .i_ms_pc         (i_ms_pc),
    .i_ms_inst       (i_ms_inst),
    .o_gpr_we        (gpr_we),
    .o_gpr_waddr     (gpr_waddr),
    .o_gpr_wdata     (gpr_wdata),
    .o_csr_we        (csr_we),
    .o_csr_waddr     (csr_waddr),
    .o_csr_wdata     (csr_wdata),
    .o_commit_valid  (o_commit_valid),
    .o_commit_pc     (o_commit_pc),
    .o_commit_inst   (o_commit_inst)
  );

  gpr_file u_gpr_file (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_we     (gpr_we),
    .i_waddr  (gpr_waddr),
    .i_wdata  (gpr_wdata),
    .i_raddr1 (i_ds_rs1),
    .i_raddr2 (i_ds_rs2),
    .o_rdata1 (gpr_rdata1),
    .o_rdata2 (gpr_rdata2)
  );

  csr_file u_csr_file (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_we     (csr_we),
    .i_waddr  (csr_waddr),
    .i_wdata  (csr_wdata),
    .i_raddr  (i_ds_csr_addr),
    .o_rdata  (csr_rdata)
  );

  // same write signals double as the bypass bus
  operand_forward u_operand_forward (
    .i_ds_rs1      (i_ds_rs1),
    .i_ds_rs2      (i_ds_rs2),
    .i_ds_csr_addr (i_ds_csr_addr),
    .i_gpr_we      (gpr_we),
    .i_gpr_waddr   (gpr_waddr),
    .i_gpr_wdata   (gpr_wdata),
    .i_csr_we      (csr_we),
    .i_csr_waddr   (csr_waddr),
    .i_csr_wdata   (csr_wdata),
    .i_gpr_rdata1  (gpr_rdata1),
    .i_gpr_rdata2  (gpr_rdata2),
    .i_csr_rdata   (csr_rdata),
    .o_rs1_val     (o_ds_rs1_val),
    .o_rs2_val     (o_ds_rs2_val),
    .o_csr_val     (o_ds_csr_val)
  );

endmodule

// File: verification/tb_clock_gen.sv
// Testbench clock source with a 10 ns period
`timescale 1ns/100ps

module tb_clock_gen (
  output logic o_clk
);

  localparam real HALF_PERIOD_NS = 5.0;

  initial begin
    o_clk = 1'b0;
    forever begin
      #(HALF_PERIOD_NS) o_clk = ~o_clk;
    end
  end

endmodule

// File: verification/wb_backend_props.sv
// Concurrent checks on the write-back stage enables and commit trace
`timescale 1ns/100ps

module wb_backend_props
  import wb_pkg::*;
(
  input logic                   i_clk,
  input logic                   i_arst_n,
  input logic                   i_gpr_we,
  input logic [GPR_ADDR_WD-1:0] i_gpr_waddr,
  input logic                   i_csr_we,
  input logic                   i_commit_valid
);

  int fail_count = 0;

  commit_low_in_reset: assert property (@(posedge i_clk) !i_arst_n |-> !i_commit_valid)
    else begin
      $error("commit valid high while reset is asserted");
      fail_count++;
    end

  no_x0_write: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    i_gpr_we |-> (i_gpr_waddr != '0))
    else begin
      $error("gpr write enable raised for x0");
      fail_count++;
    end

  // a write only ever comes from a committing instruction
  we_needs_commit: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    (i_gpr_we || i_csr_we) |-> i_commit_valid)
    else begin
      $error("write enable without commit valid");
      fail_count++;
    end

endmodule

bind wb_stage wb_backend_props u_props (
  .i_clk          (i_clk),
  .i_arst_n       (i_arst_n),
  .i_gpr_we       (o_gpr_we),
  .i_gpr_waddr    (o_gpr_waddr),
  .i_csr_we       (o_csr_we),
  .i_commit_valid (o_commit_valid)
);

// File: verification/tb_checker.sv
// Checker that compares the back end outputs with the reference values each cycle
`timescale 1ns/100ps

module tb_checker (
  input  logic        i_clk,
  input  logic        i_chk_en,
  input  int          i_test_id,
  input  logic        i_test_done,
  input  logic        i_all_done,
  // reference values
  input  logic [31:0] i_exp_rs1_val,
  input  logic [31:0] i_exp_rs2_val,
  input  logic [31:0] i_exp_csr_val,
  input  logic        i_exp_commit_valid,
  input  logic [31:0] i_exp_commit_pc,
  input  logic [31:0] i_exp_commit_inst,
  // observed DUT outputs
  input  logic [31:0] i_rs1_val,
  input  logic [31:0] i_rs2_val,
  input  logic [31:0] i_csr_val,
  input  logic        i_commit_valid,
  input  logic [31:0] i_commit_pc,
  input  logic [31:0] i_commit_inst,
  output int          o_err_total
);

  int test_errs   = 0;
  int test_checks = 0;
  int tests_run   = 0;
  int checks_all  = 0;

  initial o_err_total = 0;

  function automatic string test_label(input int id);
    case (id)
      1: return "gpr_write_read";
      2: return "x0_hardwired";
      3: return "gpr_bypass";
      4: return "csr_write_read";
      5: return "commit_trace";
      6: return "random_stream";
      default: return "unknown";
    endcase
  endfunction

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    test_checks++;
    if (act !== exp) begin
      $display("[ERROR] %s %s expected %h actual %h at %0t",
               test_label(i_test_id), what, exp, act, $time);
      test_errs++;
      o_err_total++;
    end
  endtask

  // inputs settle at the falling edge, so values here are the pre-edge ones
  always @(posedge i_clk) begin
    if (i_chk_en) begin
      check_value("rs1_val", i_exp_rs1_val, i_rs1_val);
      check_value("rs2_val", i_exp_rs2_val, i_rs2_val);
      check_value("csr_val", i_exp_csr_val, i_csr_val);
      check_value("commit_valid", {31'd0, i_exp_commit_valid}, {31'd0, i_commit_valid});
      check_value("commit_pc", i_exp_commit_pc, i_commit_pc);
      check_value("commit_inst", i_exp_commit_inst, i_commit_inst);
    end
  end

  always @(posedge i_test_done) begin
    $display("test %0d %s finished: %0d checks, %0d mismatches",
             i_test_id, test_label(i_test_id), test_checks, test_errs);
    tests_run++;
    checks_all += test_checks;
    test_errs   = 0;
    test_checks = 0;
  end

  always @(posedge i_all_done) begin
    $display("summary: %0d tests, %0d checks, %0d mismatches",
             tests_run, checks_all, o_err_total);
  end

endmodule

// File: verification/tb_top.sv
// Testbench top for the write-back back end with stimulus, shadow model and watchdog
`timescale 1ns/100ps

module tb_top;
  import wb_pkg::*;

  // cycles per test, used to size the watchdog
  localparam int TEST_CYCLES = 62 + 4 + 16 + 15 + 12 + 400;
  localparam int RESET_CYCLES = 16;
  localparam int WATCHDOG_NS = (RESET_CYCLES + TEST_CYCLES + 20) * 10 + 200;

  logic        clk;
  logic        arst_n;
  logic        ms_valid, ms_gpr_wen, ms_csr_wen;
  logic [4:0]  ms_rd;
  logic [31:0] ms_gpr_result, ms_csr_result, ms_pc, ms_inst;
  logic [11:0] ms_csr_addr;
  logic [4:0]  ds_rs1, ds_rs2;
  logic [11:0] ds_csr_addr;
  logic [31:0] rs1_val, rs2_val, csr_val, commit_pc, commit_inst;
  logic        commit_valid;
  logic [31:0] exp_rs1, exp_rs2, exp_csr, exp_pc, exp_inst;
  logic        exp_valid;
  logic        chk_en, test_done, all_done;
  int          test_id;
  int          err_total;
  int          seed = 87484;
  logic [31:0] pc_cnt;

  // shadow state and the instruction sitting in write-back
  logic [31:0] gpr_model [32];
  logic [31:0] csr_model [4];
  logic        pend_valid, pend_gpr_wen, pend_csr_wen;
  logic [4:0]  pend_rd;
  logic [11:0] pend_csr_addr;
  logic [31:0] pend_gpr_data, pend_csr_data, pend_pc, pend_inst;

  tb_clock_gen u_clk (.o_clk(clk));

  wb_backend_top dut0 (
    .i_clk(clk), .i_arst_n(arst_n),
    .i_ms_valid(ms_valid), .i_ms_gpr_wen(ms_gpr_wen), .i_ms_rd(ms_rd),
    .i_ms_gpr_result(ms_gpr_result), .i_ms_csr_wen(ms_csr_wen),
    .i_ms_csr_addr(ms_csr_addr), .i_ms_csr_result(ms_csr_result),
    .i_ms_pc(ms_pc), .i_ms_inst(ms_inst),
    .i_ds_rs1(ds_rs1), .i_ds_rs2(ds_rs2), .i_ds_csr_addr(ds_csr_addr),
    .o_ds_rs1_val(rs1_val), .o_ds_rs2_val(rs2_val), .o_ds_csr_val(csr_val),
    .o_commit_valid(commit_valid), .o_commit_pc(commit_pc), .o_commit_inst(commit_inst)
  );

  tb_checker u_checker (
    .i_clk(clk), .i_chk_en(chk_en), .i_test_id(test_id),
    .i_test_done(test_done), .i_all_done(all_done),
    .i_exp_rs1_val(exp_rs1), .i_exp_rs2_val(exp_rs2), .i_exp_csr_val(exp_csr),
    .i_exp_commit_valid(exp_valid), .i_exp_commit_pc(exp_pc),
    .i_exp_commit_inst(exp_inst),
    .i_rs1_val(rs1_val), .i_rs2_val(rs2_val), .i_csr_val(csr_val),
    .i_commit_valid(commit_valid), .i_commit_pc(commit_pc),
    .i_commit_inst(commit_inst), .o_err_total(err_total)
  );

  function automatic int csr_slot(input logic [11:0] addr);
    case (addr)
      12'h300: return 0;
      12'h305: return 1;
      12'h341: return 2;
      12'h342: return 3;
      default: return -1;
    endcase
  endfunction

  // value a decode read should see with pending write-back data winning
  function automatic logic [31:0] expected_read(input bit is_csr, input logic [11:0] addr);
    int slot;
    slot = csr_slot(addr);
    if (!is_csr) begin
      if (addr[4:0] == 5'd0) return 32'd0;
      if (pend_valid && pend_gpr_wen && pend_rd == addr[4:0]) return pend_gpr_data;
      return gpr_model[addr[4:0]];
    end
    if (slot < 0) return 32'd0;
    if (pend_valid && pend_csr_wen && pend_csr_addr == addr) return pend_csr_data;
    return csr_model[slot];
  endfunction

  // mirrors one rising edge by retiring the pending write and latching the inputs
  task automatic advance_model();
    int slot;
    slot = csr_slot(pend_csr_addr);
    if (pend_valid) begin
      if (pend_gpr_wen && pend_rd != 5'd0) gpr_model[pend_rd] = pend_gpr_data;
      if (pend_csr_wen && slot >= 0) csr_model[slot] = pend_csr_data;
    end
    pend_valid = ms_valid;
    if (ms_valid) begin
      pend_gpr_wen  = ms_gpr_wen;
      pend_rd       = ms_rd;
      pend_gpr_data = ms_gpr_result;
      pend_csr_wen  = ms_csr_wen;
      pend_csr_addr = ms_csr_addr;
      pend_csr_data = ms_csr_result;
      pend_pc       = ms_pc;
      pend_inst     = ms_inst;
    end
  endtask

  task automatic drive_cycle(input logic v, input logic gw, input logic [4:0] rd,
                             input logic [31:0] gd, input logic cw, input logic [11:0] ca,
                             input logic [31:0] cd, input logic [4:0] r1,
                             input logic [4:0] r2, input logic [11:0] cr);
    @(negedge clk);
    advance_model();
    pc_cnt        = pc_cnt + 32'd4;
    ms_valid      = v;
    ms_gpr_wen    = gw;
    ms_rd         = rd;
    ms_gpr_result = gd;
    ms_csr_wen    = cw;
    ms_csr_addr   = ca;
    ms_csr_result = cd;
    ms_pc         = pc_cnt;
    ms_inst       = $random(seed);
    ds_rs1        = r1;
    ds_rs2        = r2;
    ds_csr_addr   = cr;
    exp_rs1   = expected_read(1'b0, {7'd0, r1});
    exp_rs2   = expected_read(1'b0, {7'd0, r2});
    exp_csr   = expected_read(1'b1, cr);
    exp_valid = pend_valid;
    exp_pc    = pend_pc;
    exp_inst  = pend_inst;
  endtask

  task automatic random_cycle();
    logic [11:0] ca;
    logic [2:0]  sel;
    sel = $random(seed);
    case (sel)
      3'd0: ca = CSR_MSTATUS;
      3'd1: ca = CSR_MTVEC;
      3'd2: ca = CSR_MEPC;
      3'd3: ca = CSR_MCAUSE;
      default: ca = $random(seed);
    endcase
    drive_cycle($random(seed), $random(seed), $random(seed), $random(seed),
                $random(seed), ca, $random(seed), $random(seed), $random(seed),
                sel[0] ? ca : CSR_MEPC);
  endtask

  task automatic end_test();
    @(posedge clk);
    #1 test_done = 1'b1;
    #1 test_done = 1'b0;
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("Errors found");
    $display("watchdog expired before the tests completed");
    $finish;
  end

  initial begin
    logic [4:0]  rd;
    logic [11:0] csr_list [5];
    arst_n = 1'b1;
    {ms_valid, ms_gpr_wen, ms_csr_wen, ms_rd, ms_csr_addr} = '0;
    {ms_gpr_result, ms_csr_result, ms_pc, ms_inst} = '0;
    {ds_rs1, ds_rs2, ds_csr_addr} = '0;
    {exp_rs1, exp_rs2, exp_csr, exp_valid, exp_pc, exp_inst} = '0;
    {pend_valid, pend_gpr_wen, pend_csr_wen, pend_rd, pend_csr_addr} = '0;
    {pend_gpr_data, pend_csr_data, pend_pc, pend_inst} = '0;
    for (int i = 0; i < 32; i++) gpr_model[i] = '0;
    for (int i = 0; i < 4; i++) csr_model[i] = '0;
    chk_en = 1'b0;
    test_done = 1'b0;
    all_done = 1'b0;
    test_id = 1;
    pc_cnt = 32'h8000_0000;
    csr_list = '{CSR_MSTATUS, CSR_MTVEC, CSR_MEPC, CSR_MCAUSE, 12'h123};
    // clean falling reset edge ahead of the first clock edge
    #1 arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    chk_en = 1'b1;

    for (int i = 1; i < 32; i++) drive_cycle(1, 1, i, $random(seed), 0, 0, 0, 0, 0, 0);
    for (int i = 1; i < 32; i++) drive_cycle(0, 0, 0, 0, 0, 0, 0, i, 32 - i, 0);
    end_test();

    test_id = 2;
    drive_cycle(1, 1, 0, 32'hdead_beef, 0, 0, 0, 0, 0, 0);
    for (int i = 0; i < 3; i++) drive_cycle(0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    end_test();

    test_id = 3;
    for (int k = 0; k < 8; k++) begin
      rd = ({$random(seed)} % 31) + 1;
      drive_cycle(1, 1, rd, $random(seed), 0, 0, 0, 0, 0, 0);
      drive_cycle(0, 0, 0, 0, 0, 0, 0, rd, rd, 0);
    end
    end_test();

    test_id = 4;
    foreach (csr_list[j]) begin
      drive_cycle(1, 0, 0, 0, 1, csr_list[j], $random(seed), 0, 0, csr_list[j]);
      drive_cycle(0, 0, 0, 0, 0, 0, 0, 0, 0, csr_list[j]);
      drive_cycle(0, 0, 0, 0, 0, 0, 0, 0, 0, csr_list[j]);
    end
    end_test();

    test_id = 5;
    for (int i = 0; i < 12; i++) drive_cycle(i % 3 != 1, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    end_test();

    test_id = 6;
    repeat (400) random_cycle();
    end_test();

    all_done = 1'b1;
    #1;
    if (err_total == 0 && dut0.u_wb_stage.u_props.fail_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// File: list.f
hdl/wb_pkg.sv
hdl/wb_stage.sv
hdl/gpr_file.sv
hdl/csr_file.sv
hdl/operand_forward.sv
hdl/wb_backend_top.sv
verification/tb_clock_gen.sv
verification/wb_backend_props.sv
verification/tb_checker.sv
verification/tb_top.sv

// File: Bender.yml
package:
  name: wb_backend

sources:
  - hdl/wb_pkg.sv
  - hdl/wb_stage.sv
  - hdl/gpr_file.sv
  - hdl/csr_file.sv
  - hdl/operand_forward.sv
  - hdl/wb_backend_top.sv
  - target: test
    files:
      - verification/tb_clock_gen.sv
      - verification/wb_backend_props.sv
      - verification/tb_checker.sv
      - verification/tb_top.sv
